// File: chan_xfer.f
+incdir+design
design/chan_xfer_pkg.sv
design/lane_dispatch.sv
design/async_fifo.sv
design/lane_arbiter.sv
design/chan_xfer_top.sv
sim/chan_xfer_tb.sv

// File: Makefile
# Verilator build and run for the chan_xfer testbench

TOOL    = verilator
FLAGS   = --timing
TOP     = chan_xfer_tb
FLIST   = chan_xfer.f
BUILD   = obj_dir
LOG     = sim.log
PASS    = RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: sim/chan_xfer_tb.sv
`timescale 1ns/10ps
`include "chan_xfer_defines.svh"

module chan_xfer_tb;
    import chan_xfer_pkg::*;

    logic        w_clk = 1'b0;
    logic        r_clk = 1'b0;
    logic        rst_;
    logic        in_trigger;
    cx_word_t    in_word;
    logic        in_ready;
    logic [15:0] drop_count;
    logic        out_valid;
    cx_word_t    out_word;

    cx_word_t    model_q [`CX_LANES][$];  // Accepted words per channel
    logic [15:0] model_drops;
    logic [31:0] lfsr_state;
    int          word_count;
    int          value_errors;
    int          other_errors;

    chan_xfer_top chan_xfer_top_i (
        .w_clk      (w_clk),
        .r_clk      (r_clk),
        .rst_       (rst_),
        .in_trigger (in_trigger),
        .in_word    (in_word),
        .in_ready   (in_ready),
        .drop_count (drop_count),
        .out_valid  (out_valid),
        .out_word   (out_word)
    );

    // ==============================
    // Clocks and random source
    // ==============================
    always #5 r_clk = ~r_clk;
    always #3.5 w_clk = ~w_clk;     // Asynchronous to r_clk

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic cx_word_t random_word();
        cx_word_t    w;
        logic [31:0] bits;
        bits   = take_bits(`CX_CHAN_W);
        w.chan = lane_id_t'(bits);
        bits   = take_bits(`CX_DATA_W);
        w.data = bits[`CX_DATA_W-1:0];
        return w;
    endfunction

    function automatic bit queues_empty();
        for (int c = 0; c < `CX_LANES; c++) begin
            if (model_q[c].size() != 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    // ==============================
    // Stimulus and model tasks
    // ==============================
    // One w_clk cycle of stimulus with the model update at mid cycle
    task automatic write_cycle(input logic trig, input cx_word_t word);
        @(posedge w_clk);
        #1;
        in_trigger = trig;
        in_word    = word;
        #2;
        if (trig) begin
            if (in_ready) model_q[word.chan].push_back(word);
            else model_drops = model_drops + 16'd1;
        end
    endtask

    task automatic check_reset_state(input string when);
        if (out_valid !== 1'b0) begin
            $display("** Error: out_valid %s expected 0x0 got 0x%h", when, out_valid);
            value_errors++;
        end
        if (in_ready !== 1'b1) begin
            $display("** Error: in_ready %s expected 0x1 got 0x%h", when, in_ready);
            value_errors++;
        end
        if (drop_count !== 16'h0000) begin
            $display("** Error: drop_count %s expected 0x0000 got 0x%h", when, drop_count);
            value_errors++;
        end
    endtask

    task automatic check_drops(input string when);
        if (drop_count !== model_drops) begin
            $display("** Error: drop_count %s expected 0x%h got 0x%h",
                     when, model_drops, drop_count);
            value_errors++;
        end
    endtask

    task automatic drain_queues(input string phase);
        int cycles;
        cycles = 0;
        while (!queues_empty() && cycles < 200) begin
            @(posedge r_clk);
            cycles++;
        end
        for (int c = 0; c < `CX_LANES; c++) begin
            if (model_q[c].size() != 0) begin
                $display("Channel %0d still holds %0d words 200 cycles after the %s",
                         c, model_q[c].size(), phase);
                other_errors++;
            end
        end
    endtask

    // Output check on the falling edge of r_clk
    always @(negedge r_clk) begin : check_output
        cx_word_t exp_word;
        if (rst_ === 1'b1 && out_valid === 1'b1) begin
            word_count++;
            if (model_q[out_word.chan].size() == 0) begin
                $display("Word arrived on channel %0d while no word was expected there",
                         out_word.chan);
                other_errors++;
            end else begin
                exp_word = model_q[out_word.chan].pop_front();
                if (out_word !== exp_word) begin
                    $display("** Error: out_word expected 0x%h got 0x%h", exp_word, out_word);
                    value_errors++;
                end
            end
        end
    end

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        cx_word_t    word;
        logic [31:0] bits;
        logic [15:0] drops_before;

        rst_         = 1'b0;
        in_trigger   = 1'b0;
        in_word      = '0;
        lfsr_state   = 32'h3feb_49d8;
        model_drops  = '0;
        word_count   = 0;
        value_errors = 0;
        other_errors = 0;

        repeat (2) @(posedge r_clk);
        #1;
        check_reset_state("during reset");
        repeat (2) @(posedge r_clk);
        #1;
        rst_ = 1'b1;
        @(posedge r_clk);
        #1;
        check_reset_state("after reset");

        // Dense burst that outruns the single read port
        for (int n = 0; n < 500; n++) begin
            bits = take_bits(4);
            word = random_word();
            write_cycle(|bits[3:0], word);
        end
        write_cycle(1'b0, word);
        check_drops("after dense burst");
        if (model_drops == 16'd0) begin
            $display("The dense burst filled no lane and no word was dropped");
            other_errors++;
        end

        // Sparse phase of about one write in four cycles
        for (int n = 0; n < 200; n++) begin
            bits = take_bits(2);
            word = random_word();
            write_cycle(bits[1:0] == 2'b00, word);
        end
        write_cycle(1'b0, word);
        drain_queues("sparse phase");

        // Every lane has room again
        for (int c = 0; c < `CX_LANES; c++) begin
            word.chan = lane_id_t'(c);
            write_cycle(1'b0, word);
            if (in_ready !== 1'b1) begin
                $display("** Error: in_ready for channel %0d expected 0x1 got 0x%h",
                         c, in_ready);
                value_errors++;
            end
        end
        for (int c = 0; c < `CX_LANES; c++) begin
            word         = random_word();
            word.chan    = lane_id_t'(c);
            drops_before = model_drops;
            write_cycle(1'b1, word);
            if (model_drops != drops_before) begin
                $display("The final write to channel %0d was rejected", c);
                other_errors++;
            end
        end
        write_cycle(1'b0, word);
        drain_queues("final writes");
        repeat (4) @(posedge r_clk);    // Catch any stray output
        check_drops("at end");

        $display("Checked %0d words, %0d value errors, %0d other failures, %0d drops",
                 word_count, value_errors, other_errors, model_drops);
        if (value_errors + other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: design/chan_xfer_top.sv
`timescale 1ns/10ps
`include "chan_xfer_defines.svh"

module chan_xfer_top (
    input  logic                    w_clk,
    input  logic                    r_clk,
    input  logic                    rst_,
    input  logic                    in_trigger,
    input  chan_xfer_pkg::cx_word_t in_word,
    output logic                    in_ready,
    output logic [15:0]             drop_count,
    output logic                    out_valid,
    output chan_xfer_pkg::cx_word_t out_word
);
    import chan_xfer_pkg::*;

    logic [`CX_LANES-1:0] w_ready;     // Per-lane space
    logic [`CX_LANES-1:0] w_trigger;
    cx_word_t             w_word;      // Same word offered to all lanes
    logic [`CX_LANES-1:0] r_ready;     // Per-lane data present
    logic [`CX_LANES-1:0] r_trigger;
    cx_word_t             r_word [`CX_LANES];

    // ==============================
    // Write clock domain
    // ==============================
    lane_dispatch lane_dispatch_i (
        .w_clk        (w_clk),
        .rst_         (rst_),
        .in_trigger   (in_trigger),
        .in_word      (in_word),
        .in_ready     (in_ready),
        .lane_ready   (w_ready),
        .lane_trigger (w_trigger),
        .lane_word    (w_word),
        .drop_count   (drop_count)
    );

    // One FIFO per channel
    for (genvar g = 0; g < `CX_LANES; g++) begin : g_lane
        async_fifo #(
            .DEPTH_LOG2 (`CX_DEPTH_LOG2)
        ) async_fifo_i (
            .w_clk     (w_clk),
            .rst_      (rst_),
            .w_trigger (w_trigger[g]),
            .w_word    (w_word),
            .w_ready   (w_ready[g]),
            .r_clk     (r_clk),
            .r_trigger (r_trigger[g]),
            .r_word    (r_word[g]),
            .r_ready   (r_ready[g])
        );
    end

    // Read clock domain
    lane_arbiter lane_arbiter_i (
        .r_clk        (r_clk),
        .rst_         (rst_),
        .lane_ready   (r_ready),
        .lane_word    (r_word),
        .lane_trigger (r_trigger),
        .out_valid    (out_valid),
        .out_word     (out_word)
    );

endmodule

// File: design/lane_arbiter.sv
`timescale 1ns/10ps
`include "chan_xfer_defines.svh"

module lane_arbiter (
    input  logic                    r_clk,
    input  logic                    rst_,
    input  logic [`CX_LANES-1:0]    lane_ready,
    input  chan_xfer_pkg::cx_word_t lane_word [`CX_LANES],
    output logic [`CX_LANES-1:0]    lane_trigger,
    output logic                    out_valid,
    output chan_xfer_pkg::cx_word_t out_word
);
    import chan_xfer_pkg::*;

    lane_id_t last_grant;   // Lane popped most recently
    lane_id_t grant_idx;
    logic     grant_any;

    // ==============================
    // Round-robin search
    // ==============================
    // Starts one past the last grant, wraps through the tag width
    always_comb begin
        lane_id_t idx;
        grant_any = 1'b0;
        grant_idx = last_grant;
        for (int i = 1; i <= `CX_LANES; i++) begin
            idx = last_grant + lane_id_t'(i);
            if (!grant_any && lane_ready[idx]) begin
                grant_any = 1'b1;
                grant_idx = idx;
            end
        end
    end

    always_comb begin
        lane_trigger = '0;
        if (grant_any) begin
            lane_trigger[grant_idx] = 1'b1;  // Pop the winner
        end
    end

    // ==============================
    // Output stage
    // ==============================
    always_ff @(posedge r_clk or negedge rst_) begin
        if (!rst_) begin
            last_grant <= lane_id_t'(`CX_LANES - 1);  // Lane 0 goes first
            out_valid  <= 1'b0;
        end else begin
            out_valid <= grant_any;
            if (grant_any) begin
                last_grant <= grant_idx;
            end
        end
    end

    // Word captured in the same edge as the pop
    always_ff @(posedge r_clk) begin
        if (grant_any) begin
            out_word <= lane_word[grant_idx];
        end
    end

endmodule

// File: design/async_fifo.sv
`timescale 1ns/10ps
`include "chan_xfer_defines.svh"

module async_fifo #(
    parameter int DEPTH_LOG2 = `CX_DEPTH_LOG2
) (
    input  logic                    w_clk,
    input  logic                    rst_,
    input  logic                    w_trigger,    // Caller has checked w_ready
    input  chan_xfer_pkg::cx_word_t w_word,
    output logic                    w_ready,      // Not full
    input  logic                    r_clk,
    input  logic                    r_trigger,
    output chan_xfer_pkg::cx_word_t r_word,       // Head entry
    output logic                    r_ready       // Not empty
);
    import chan_xfer_pkg::*;

    // One extra pointer bit tells full from empty
    localparam int PTR_W = DEPTH_LOG2 + 1;
    localparam int DEPTH = 1 << DEPTH_LOG2;

    // ==============================
    // Write side
    // ==============================
    logic [PTR_W-1:0] w_bin;
    logic [PTR_W-1:0] w_gray;
    logic [PTR_W-1:0] w_bin_next;
    logic [PTR_W-1:0] w_gray_next;
    logic [PTR_W-1:0] w_rgray_meta;    // First sync stage
    logic [PTR_W-1:0] w_rgray;         // Read pointer in w_clk domain
    logic             w_full;

    // Read side pointers
    logic [PTR_W-1:0] r_bin;
    logic [PTR_W-1:0] r_gray;
    logic [PTR_W-1:0] r_bin_next;
    logic [PTR_W-1:0] r_gray_next;
    logic [PTR_W-1:0] r_wgray_meta;
    logic [PTR_W-1:0] r_wgray;         // Write pointer in r_clk domain
    logic             r_not_empty;
    logic             r_pop;

    assign w_bin_next  = w_trigger ? w_bin + 1'b1 : w_bin;
    assign w_gray_next = (w_bin_next >> 1) ^ w_bin_next;

    always_ff @(posedge w_clk or negedge rst_) begin
        if (!rst_) begin
            w_bin        <= '0;
            w_gray       <= '0;
            w_rgray_meta <= '0;
            w_rgray      <= '0;
            w_full       <= 1'b0;
        end else begin
            w_bin        <= w_bin_next;
            w_gray       <= w_gray_next;
            w_rgray_meta <= r_gray;
            w_rgray      <= w_rgray_meta;
            // Full when write leads read by exactly one lap
            w_full <= (w_gray_next == {~w_rgray[PTR_W-1 -: 2], w_rgray[PTR_W-3:0]});
        end
    end

    assign w_ready = ~w_full;

    // ==============================
    // Read side
    // ==============================
    assign r_pop       = r_trigger & r_ready;
    assign r_bin_next  = r_pop ? r_bin + 1'b1 : r_bin;
    assign r_gray_next = (r_bin_next >> 1) ^ r_bin_next;

    always_ff @(posedge r_clk or negedge rst_) begin
        if (!rst_) begin
            r_bin        <= '0;
            r_gray       <= '0;
            r_wgray_meta <= '0;
            r_wgray      <= '0;
            r_not_empty  <= 1'b0;
        end else begin
            r_bin        <= r_bin_next;
            r_gray       <= r_gray_next;
            r_wgray_meta <= w_gray;
            r_wgray      <= r_wgray_meta;
            r_not_empty  <= (r_gray_next != r_wgray);
        end
    end

    assign r_ready = r_not_empty;

    // ==============================
    // Storage
    // ==============================
    cx_word_t mem [DEPTH];

    always_ff @(posedge w_clk) begin
        if (w_trigger) begin
            mem[w_bin[DEPTH_LOG2-1:0]] <= w_word;
        end
    end

    // Reads the next address so a pop shows the new head at once
    always_ff @(posedge r_clk) begin
        r_word <= mem[r_bin_next[DEPTH_LOG2-1:0]];
    end

endmodule

// File: design/lane_dispatch.sv
`timescale 1ns/10ps
`include "chan_xfer_defines.svh"

module lane_dispatch (
    input  logic                    w_clk,
    input  logic                    rst_,
    input  logic                    in_trigger,
    input  chan_xfer_pkg::cx_word_t in_word,
    output logic                    in_ready,
    input  logic [`CX_LANES-1:0]    lane_ready,
    output logic [`CX_LANES-1:0]    lane_trigger,
    output chan_xfer_pkg::cx_word_t lane_word,
    output logic [15:0]             drop_count
);
    import chan_xfer_pkg::*;

    lane_id_t             sel_lane;
    logic [`CX_LANES-1:0] sel_onehot;
    logic                 accept;
    logic                 reject;

    // ==============================
    // Lane select and strobe gating
    // ==============================
    assign sel_lane = in_word.chan;
    assign in_ready = lane_ready[sel_lane];  // Follows the tag every cycle

    always_comb begin
        sel_onehot = '0;
        sel_onehot[sel_lane] = 1'b1;
    end

    assign accept = in_trigger & in_ready;
    assign reject = in_trigger & ~in_ready;

    // Strobe only reaches a lane with room
    assign lane_trigger = sel_onehot & {`CX_LANES{accept}};
    assign lane_word    = in_word;          // Shared by all lanes

    // ==============================
    // Drop counter
    // ==============================
    // Saturates at all ones
    always_ff @(posedge w_clk or negedge rst_) begin
        if (!rst_) begin
            drop_count <= '0;
        end else if (reject && !(&drop_count)) begin
            drop_count <= drop_count + 16'd1;
        end
    end

endmodule

// File: design/chan_xfer_pkg.sv
`include "chan_xfer_defines.svh"

package chan_xfer_pkg;

    // ==============================
    // Shared types
    // ==============================

    // Lane or channel number
    typedef logic [`CX_CHAN_W-1:0] lane_id_t;

    // Tagged word as it moves through a lane
    typedef struct packed {
        lane_id_t              chan;  // Destination lane
        logic [`CX_DATA_W-1:0] data;  // Payload
    } cx_word_t;

endpackage

// File: design/chan_xfer_defines.svh
`ifndef CHAN_XFER_DEFINES_SVH
`define CHAN_XFER_DEFINES_SVH

// Lane count as a power of two
`define CX_LANES      4
`define CX_CHAN_W     2     // log2 of CX_LANES

// Payload width of one word
`define CX_DATA_W     16

// Words per lane as a power of two
`define CX_DEPTH_LOG2 4

`endif
